/* Bender.yml */
package:
  name: rib

sources:
  - logic/rib_pkg.sv
  - logic/rib_arbiter.sv
  - logic/rib_request_route.sv
  - logic/rib_response_route.sv
  - logic/rib.sv
  - target: simulation
    files:
      - bench/rib_checker.sv
      - bench/tb_rib.sv

/* bench/rib_checker.sv */
`timescale 1ns/1ps

module rib_checker #(
    parameter int NUM_SLAVES = 6
) (
    input  logic                                        clk,
    input  logic                                        reset_i,
    input  logic [8*16-1:0]                             test_name_i,
    input  rib_pkg::mst_req_t [rib_pkg::NUM_MASTERS-1:0] mst_req_i,
    input  rib_pkg::data_t [NUM_SLAVES-1:0]             slv_rdata_i,
    input  rib_pkg::data_t [rib_pkg::NUM_MASTERS-1:0]   mst_rdata_i,
    input  rib_pkg::slv_req_t [NUM_SLAVES-1:0]          slv_req_i,
    input  logic                                        hold_i,
    output int                                          err_count_o,
    output int                                          check_count_o
);

    import rib_pkg::*;

    // bus order from highest to lowest priority, 3 bits per entry
    localparam logic [17:0] ORDER = {3'd4, 3'd5, 3'd3, 3'd1, 3'd2, 3'd0};

    function automatic void predict(
        input  mst_req_t [NUM_MASTERS-1:0] req,
        input  data_t [NUM_SLAVES-1:0]     rdata,
        output data_t [NUM_MASTERS-1:0]    exp_rdata,
        output slv_req_t [NUM_SLAVES-1:0]  exp_slv,
        output logic                       exp_hold
    );
        int winner;
        int sel;
        winner = -1;
        for (int p = 0; p < NUM_MASTERS; p++) begin
            if (winner < 0 && req[ORDER[3*p +: 3]].req) begin
                winner = ORDER[3*p +: 3];
            end
        end
        for (int m = 0; m < NUM_MASTERS; m++) begin
            exp_rdata[m] = (m == 1 || m == 4) ? INST_NOP : 32'h0;  // fetch ports idle on nop
        end
        exp_slv  = '0;
        exp_hold = (winner >= 0) && (winner != 1);
        if (winner >= 0) begin
            sel = req[winner].addr[31:28];
            if (sel < NUM_SLAVES) begin
                exp_slv[sel].we    = req[winner].we;
                exp_slv[sel].addr  = {4'h0, req[winner].addr[27:0]};
                exp_slv[sel].wdata = req[winner].wdata;
                exp_rdata[winner]  = rdata[sel];
            end
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] got_v);
        if (got_v !== exp_v) begin
            err_count_o++;
            $display("ERR %0s exp %h got %h (test %0s, t=%0t)",
                     name, exp_v, got_v, test_name_i, $time);
        end
    endtask

    initial begin
        err_count_o   = 0;
        check_count_o = 0;
    end

    // inputs change on the rising edge, so the falling edge sees them settled
    always @(negedge clk) begin : compare
        data_t [NUM_MASTERS-1:0]   exp_rdata;
        slv_req_t [NUM_SLAVES-1:0] exp_slv;
        logic                      exp_hold;
        if (!reset_i) begin
            predict(mst_req_i, slv_rdata_i, exp_rdata, exp_slv, exp_hold);
            check_count_o++;
            check_value("hold_o", {31'h0, exp_hold}, {31'h0, hold_i});
            for (int m = 0; m < NUM_MASTERS; m++) begin
                check_value($sformatf("mst_rdata_o[%0d]", m), exp_rdata[m], mst_rdata_i[m]);
            end
            for (int s = 0; s < NUM_SLAVES; s++) begin
                check_value($sformatf("slv_req_o[%0d].we", s),
                            {31'h0, exp_slv[s].we}, {31'h0, slv_req_i[s].we});
                check_value($sformatf("slv_req_o[%0d].addr", s),
                            exp_slv[s].addr, slv_req_i[s].addr);
                check_value($sformatf("slv_req_o[%0d].wdata", s),
                            exp_slv[s].wdata, slv_req_i[s].wdata);
            end
        end
    end

endmodule

/* bench/tb_rib.sv */
`timescale 1ns/1ps

module tb_rib;

    import rib_pkg::*;

    localparam int NUM_SLAVES  = 6;
    localparam int N_DIRECTED  = 12;
    localparam int N_RANDOM    = 300;
    localparam int WATCHDOG_NS = (N_DIRECTED + N_RANDOM + 20) * 10;

    logic                       clk;
    logic                       reset_i;
    mst_req_t [NUM_MASTERS-1:0] mst_req;
    data_t [NUM_MASTERS-1:0]    mst_rdata;
    slv_req_t [NUM_SLAVES-1:0]  slv_req;
    data_t [NUM_SLAVES-1:0]     slv_rdata;
    logic                       hold;
    logic [8*16-1:0]            test_name;
    mst_req_t [NUM_MASTERS-1:0] vec;
    int                         seed;
    int                         err_count;
    int                         check_count;
    int                         errs_before;

    rib #(
        .NUM_SLAVES (NUM_SLAVES)
    ) i_dut (
        .clk         (clk),
        .reset_i     (reset_i),
        .mst_req_i   (mst_req),
        .mst_rdata_o (mst_rdata),
        .slv_req_o   (slv_req),
        .slv_rdata_i (slv_rdata),
        .hold_o      (hold)
    );

    rib_checker #(
        .NUM_SLAVES (NUM_SLAVES)
    ) i_checker (
        .clk           (clk),
        .reset_i       (reset_i),
        .test_name_i   (test_name),
        .mst_req_i     (mst_req),
        .slv_rdata_i   (slv_rdata),
        .mst_rdata_i   (mst_rdata),
        .slv_req_i     (slv_req),
        .hold_i        (hold),
        .err_count_o   (err_count),
        .check_count_o (check_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // masters in mask request slave sel, each with its own offset and data
    task automatic build_directed(input logic [NUM_MASTERS-1:0] mask, input slave_sel_t sel,
                                  output mst_req_t [NUM_MASTERS-1:0] v);
        logic [27:0] offset;
        v = '0;
        for (int m = 0; m < NUM_MASTERS; m++) begin
            offset = 28'h5a0_0100 + m;
            if (mask[m]) begin
                v[m].req   = 1'b1;
                v[m].we    = m[0];
                v[m].addr  = {sel, offset};
                v[m].wdata = 32'hd000_0000 + m;
            end
        end
    endtask

    task automatic build_random(output mst_req_t [NUM_MASTERS-1:0] v);
        logic [31:0] r;
        logic [31:0] a;
        r = $random(seed);
        for (int m = 0; m < NUM_MASTERS; m++) begin
            a          = $random(seed);
            v[m].req   = r[m] && (r[10:8] != 3'd0);  // about one in eight is an idle gap
            v[m].we    = r[m+16];
            v[m].addr  = {1'b0, a[30:0]};            // select 0..7, 6 and 7 are unmapped
            v[m].wdata = $random(seed);
        end
    endtask

    task automatic apply_vector(input mst_req_t [NUM_MASTERS-1:0] v);
        data_t [NUM_SLAVES-1:0] rd;
        for (int s = 0; s < NUM_SLAVES; s++) begin
            rd[s] = $random(seed);
        end
        @(posedge clk);
        mst_req   <= v;
        slv_rdata <= rd;
    endtask

    task automatic run_directed(input logic [NUM_MASTERS-1:0] mask, input slave_sel_t sel);
        mst_req_t [NUM_MASTERS-1:0] v;
        build_directed(mask, sel, v);
        apply_vector(v);
    endtask

    // waits for the checker to see the last vector, then reports the test
    task automatic end_test();
        @(negedge clk);
        #1;
        $display("test %0s done, %0d mismatches", test_name, err_count - errs_before);
        errs_before = err_count;
    endtask

    initial begin
        seed        = 32'hc05b;
        reset_i     = 1'b1;
        mst_req     = '0;
        slv_rdata   = '0;
        errs_before = 0;
        test_name   = "reset";
        repeat (4) @(posedge clk);
        reset_i <= 1'b0;
        test_name = "after_reset";
        end_test();

        test_name = "priority";
        run_directed(6'b111111, 4'd2);
        run_directed(6'b111110, 4'd3);
        run_directed(6'b111010, 4'd1);
        run_directed(6'b111000, 4'd4);
        run_directed(6'b110000, 4'd0);
        run_directed(6'b010000, 4'd5);
        end_test();

        test_name = "decode";
        run_directed(6'b001000, 4'd5);
        run_directed(6'b000001, 4'd0);
        end_test();

        test_name = "missing_slave";
        run_directed(6'b000100, 4'd6);
        run_directed(6'b010000, 4'hf);
        end_test();

        test_name = "hold";
        run_directed(6'b000010, 4'd3);
        end_test();

        test_name = "idle";
        run_directed(6'b000000, 4'd0);
        end_test();

        test_name = "random";
        repeat (N_RANDOM) begin
            build_random(vec);
            apply_vector(vec);
        end
        end_test();

        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("run timed out after %0d ns before all tests finished", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* compile.f */
logic/rib_pkg.sv
logic/rib_arbiter.sv
logic/rib_request_route.sv
logic/rib_response_route.sv
logic/rib.sv
bench/rib_checker.sv
bench/tb_rib.sv

/* logic/rib.sv */
`timescale 1ns/1ps

module rib #(
    parameter int NUM_SLAVES = 6
) (
    input  logic                                        clk,
    input  logic                                        reset_i,
    input  rib_pkg::mst_req_t [rib_pkg::NUM_MASTERS-1:0] mst_req_i,
    output rib_pkg::data_t [rib_pkg::NUM_MASTERS-1:0]   mst_rdata_o,
    output rib_pkg::slv_req_t [NUM_SLAVES-1:0]          slv_req_o,
    input  rib_pkg::data_t [NUM_SLAVES-1:0]             slv_rdata_i,
    output logic                                        hold_o
);

    import rib_pkg::*;

    master_idx_t grant_idx;
    logic        grant_valid;
    slave_sel_t  sel_idx;
    logic        sel_valid;

    // whole path is combinational, clk only feeds the checks
    rib_arbiter i_arbiter (
        .clk           (clk),
        .reset_i       (reset_i),
        .req_i         (mst_req_i),
        .grant_idx_o   (grant_idx),
        .grant_valid_o (grant_valid),
        .hold_o        (hold_o)
    );

    rib_request_route #(
        .NUM_SLAVES (NUM_SLAVES)
    ) i_request_route (
        .clk           (clk),
        .reset_i       (reset_i),
        .req_i         (mst_req_i),
        .grant_idx_i   (grant_idx),
        .grant_valid_i (grant_valid),
        .slv_req_o     (slv_req_o),
        .sel_idx_o     (sel_idx),
        .sel_valid_o   (sel_valid)
    );

    rib_response_route #(
        .NUM_SLAVES (NUM_SLAVES)
    ) i_response_route (
        .clk         (clk),
        .reset_i     (reset_i),
        .grant_idx_i (grant_idx),
        .sel_idx_i   (sel_idx),
        .sel_valid_i (sel_valid),
        .slv_rdata_i (slv_rdata_i),
        .mst_rdata_o (mst_rdata_o)
    );

endmodule

/* logic/rib_arbiter.sv */
`timescale 1ns/1ps

module rib_arbiter (
    input  logic                                        clk,
    input  logic                                        reset_i,
    input  rib_pkg::mst_req_t [rib_pkg::NUM_MASTERS-1:0] req_i,
    output rib_pkg::master_idx_t                        grant_idx_o,
    output logic                                        grant_valid_o,
    output logic                                        hold_o
);

    import rib_pkg::*;

    logic [NUM_MASTERS-1:0] req_vec;

    always_comb begin
        for (int m = 0; m < NUM_MASTERS; m++) begin
            req_vec[m] = req_i[m].req;
        end
    end

    // scan from lowest priority up so the last hit wins
    always_comb begin
        grant_idx_o   = '0;
        grant_valid_o = 1'b0;
        for (int p = NUM_MASTERS - 1; p >= 0; p--) begin
            if (req_vec[PRIO_ORDER[p]]) begin
                grant_idx_o   = PRIO_ORDER[p];
                grant_valid_o = 1'b1;
            end
        end
    end

    assign hold_o = grant_valid_o && (grant_idx_o != HOLD_FREE_MASTER);  // idle bus never stalls

    // a stall always points at a master that is really asking
    a_hold_has_grant: assert property (
        @(posedge clk) disable iff (reset_i)
        hold_o |-> grant_valid_o && req_vec[grant_idx_o]
    ) else $error("hold raised without a requesting grant");

endmodule

/* logic/rib_pkg.sv */
package rib_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  slave_sel_t;     // top nibble of the address
    typedef logic [2:0]  master_idx_t;

    // request bundle as a master presents it
    typedef struct packed {
        logic  req;
        logic  we;
        addr_t addr;
        data_t wdata;
    } mst_req_t;

    // request bundle as a slave sees it
    typedef struct packed {
        logic  we;
        addr_t addr;                      // select bits already cleared
        data_t wdata;
    } slv_req_t;

    localparam int NUM_MASTERS = 6;
    localparam int MAX_SLAVES  = 2 ** $bits(slave_sel_t);
    localparam int SEL_LSB     = $bits(addr_t) - $bits(slave_sel_t);

    // entry 0 wins, entry 5 loses
    localparam master_idx_t [NUM_MASTERS-1:0] PRIO_ORDER = {
        3'd4,
        3'd5,
        3'd3,
        3'd1,
        3'd2,
        3'd0
    };

    localparam logic [NUM_MASTERS-1:0] FETCH_MASK = 6'b01_0010;  // masters 1 and 4

    // instruction fetch may proceed without stalling the pipeline
    localparam master_idx_t HOLD_FREE_MASTER = 3'd1;

    localparam data_t INST_NOP = 32'h0000_0001;

endpackage

/* logic/rib_request_route.sv */
`timescale 1ns/1ps

module rib_request_route #(
    parameter int NUM_SLAVES = 6
) (
    input  logic                                        clk,
    input  logic                                        reset_i,
    input  rib_pkg::mst_req_t [rib_pkg::NUM_MASTERS-1:0] req_i,
    input  rib_pkg::master_idx_t                        grant_idx_i,
    input  logic                                        grant_valid_i,
    output rib_pkg::slv_req_t [NUM_SLAVES-1:0]          slv_req_o,
    output rib_pkg::slave_sel_t                         sel_idx_o,
    output logic                                        sel_valid_o
);

    import rib_pkg::*;

    mst_req_t              granted;
    addr_t                 slv_addr;
    logic [NUM_SLAVES-1:0] slv_we;

    if (NUM_SLAVES < 1 || NUM_SLAVES > MAX_SLAVES) begin : g_cfg_check
        $error("NUM_SLAVES must lie between 1 and %0d", MAX_SLAVES);
    end

    assign granted = req_i[grant_idx_i];

    assign sel_idx_o   = granted.addr[SEL_LSB +: $bits(slave_sel_t)];
    assign sel_valid_o = grant_valid_i && (sel_idx_o < NUM_SLAVES);  // no slave behind high selects

    // slave sees only its local offset
    assign slv_addr = addr_t'(granted.addr[SEL_LSB-1:0]);

    always_comb begin
        for (int s = 0; s < NUM_SLAVES; s++) begin
            slv_req_o[s] = '0;
            if (sel_valid_o && (sel_idx_o == s)) begin
                slv_req_o[s].we    = granted.we;
                slv_req_o[s].addr  = slv_addr;
                slv_req_o[s].wdata = granted.wdata;
            end
        end
    end

    for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_we
        assign slv_we[s] = slv_req_o[s].we;
    end

    // one write strobe at most across the whole slave side
    a_single_we: assert property (
        @(posedge clk) disable iff (reset_i)
        $onehot0(slv_we)
    ) else $error("more than one slave write enable active");

    // a write reaching a slave came from the granted master
    a_we_source: assert property (
        @(posedge clk) disable iff (reset_i)
        (|slv_we) |-> grant_valid_i && granted.req && granted.we
    ) else $error("slave write without a granted writing master");

endmodule

/* logic/rib_response_route.sv */
`timescale 1ns/1ps

module rib_response_route #(
    parameter int NUM_SLAVES = 6
) (
    input  logic                                     clk,
    input  logic                                     reset_i,
    input  rib_pkg::master_idx_t                     grant_idx_i,
    input  rib_pkg::slave_sel_t                      sel_idx_i,
    input  logic                                     sel_valid_i,
    input  rib_pkg::data_t [NUM_SLAVES-1:0]          slv_rdata_i,
    output rib_pkg::data_t [rib_pkg::NUM_MASTERS-1:0] mst_rdata_o
);

    import rib_pkg::*;

    data_t [NUM_MASTERS-1:0] idle_rdata;
    data_t                   sel_rdata;

    // fetch ports idle on a nop, data ports on zero
    for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_idle
        assign idle_rdata[m] = FETCH_MASK[m] ? INST_NOP : '0;
    end

    always_comb begin
        sel_rdata = '0;
        for (int s = 0; s < NUM_SLAVES; s++) begin
            if (sel_idx_i == s) begin
                sel_rdata = slv_rdata_i[s];
            end
        end
    end

    always_comb begin
        for (int m = 0; m < NUM_MASTERS; m++) begin
            if (sel_valid_i && (grant_idx_i == m)) begin
                mst_rdata_o[m] = sel_rdata;  // only the granted master listens
            end else begin
                mst_rdata_o[m] = idle_rdata[m];
            end
        end
    end

    // no slave selected means every master stays at rest
    a_idle_when_unselected: assert property (
        @(posedge clk) disable iff (reset_i)
        !sel_valid_i |-> mst_rdata_o == idle_rdata
    ) else $error("master read data moved without a selected slave");

endmodule
